//--- logic/ooo_settings.svh
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// ==============================
// Scheduler sizing
// ==============================

// Reservation station entries
`define RS_DEPTH 8

// Micro-ops offered by dispatch per cycle
`define DISPATCH_WIDTH 2

// Broadcast ports, port 0 is ALU and port 1 is MUL
`define CDB_WIDTH 2

// ==============================
// Datapath sizing
// ==============================

// Physical tag space and its index width
`define PHYS_REGS 32
`define TAG_WIDTH ($clog2(`PHYS_REGS))

// Operand and result width
`define XLEN 32

// Depth of the multiplier pipeline
`define MUL_STAGES 3

`endif

//--- logic/uop_pkg.sv
`include "ooo_settings.svh"

package uop_pkg;

    // ==============================
    // Encodings
    // ==============================

    // Supported operations
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        MUL,
        MULH
    } opcode_e;

    // Which lane executes the op
    typedef enum logic {
        FU_ALU,
        FU_MUL
    } fu_type_e;

    // ==============================
    // Micro-op forms
    // ==============================

    // One source operand, value only meaningful once ready
    typedef struct packed {
        logic [`TAG_WIDTH-1:0] tag;
        logic                  ready;
        logic [`XLEN-1:0]      value;
    } src_operand_t;

    // As delivered by dispatch
    typedef struct packed {
        opcode_e               opcode;
        logic [`TAG_WIDTH-1:0] dest_tag;
        src_operand_t          src1;
        src_operand_t          src2;
    } disp_uop_t;

    // As held in a station entry
    typedef struct packed {
        opcode_e               opcode;
        fu_type_e              fu_type;
        logic [`TAG_WIDTH-1:0] dest_tag;
        src_operand_t          src1;
        src_operand_t          src2;
    } rs_entry_t;

endpackage

//--- logic/cdb_pkg.sv
`include "ooo_settings.svh"

package cdb_pkg;

    // One completed result on a broadcast port
    typedef struct packed {
        logic                  valid;
        logic [`TAG_WIDTH-1:0] tag;
        logic [`XLEN-1:0]      value;
    } cdb_packet_t;

    // What a lane receives at issue
    typedef struct packed {
        logic                  valid;
        uop_pkg::opcode_e      opcode;
        logic [`TAG_WIDTH-1:0] dest_tag;
        logic [`XLEN-1:0]      src1_value;
        logic [`XLEN-1:0]      src2_value;
    } issue_pkt_t;

    // Wakeup of one waiting source from any port
    function automatic uop_pkg::src_operand_t cdb_snoop(
        input uop_pkg::src_operand_t          src,
        input cdb_packet_t [`CDB_WIDTH-1:0]   cdb
    );
        uop_pkg::src_operand_t res;
        res = src;
        for (int p = 0; p < `CDB_WIDTH; p++) begin
            // Tags are unique in flight, so at most one port hits
            if (!src.ready && cdb[p].valid && (cdb[p].tag == src.tag)) begin
                res.ready = 1'b1;
                res.value = cdb[p].value;
            end
        end
        return res;
    endfunction

endpackage

//--- logic/uop_decode.sv
`include "ooo_settings.svh"

module uop_decode
    import uop_pkg::*;
    import cdb_pkg::*;
(
    input  logic        [`DISPATCH_WIDTH-1:0] disp_valid_i,
    input  disp_uop_t   [`DISPATCH_WIDTH-1:0] disp_uop_i,
    input  cdb_packet_t [`CDB_WIDTH-1:0]      cdb_i,
    output rs_entry_t   [`DISPATCH_WIDTH-1:0] entry_o,
    output logic        [`DISPATCH_WIDTH-1:0] entry_valid_o
);

    // ==============================
    // Unit type lookup
    // ==============================

    function automatic fu_type_e fu_of(input opcode_e op);
        fu_type_e fu;
        case (op)
            MUL, MULH: fu = FU_MUL;
            default:   fu = FU_ALU;
        endcase
        return fu;
    endfunction

    // ==============================
    // Slot decode
    // ==============================

    always_comb begin
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            entry_o[s].opcode   = disp_uop_i[s].opcode;
            entry_o[s].fu_type  = fu_of(disp_uop_i[s].opcode);
            entry_o[s].dest_tag = disp_uop_i[s].dest_tag;
            // Same-cycle bypass
            // a producer broadcasting now would otherwise never be seen by the entry
            entry_o[s].src1     = cdb_snoop(disp_uop_i[s].src1, cdb_i);
            entry_o[s].src2     = cdb_snoop(disp_uop_i[s].src2, cdb_i);
        end
    end

    // Slot valid passes through with its entry
    assign entry_valid_o = disp_valid_i;

endmodule

//--- logic/disp_selector.sv
`include "ooo_settings.svh"

module disp_selector (
    input  logic [`RS_DEPTH-1:0]                      empty_i,
    input  logic [`DISPATCH_WIDTH-1:0]                disp_valid_i,
    output logic [`DISPATCH_WIDTH-1:0][`RS_DEPTH-1:0] grant_o
);

    // ==============================
    // Priority allocation
    // ==============================

    always_comb begin : grant_logic
        logic [`RS_DEPTH-1:0] avail;
        logic                 found;
        avail   = empty_i;
        grant_o = '0;
        found   = 1'b0;
        // Slot 0 first, so it always lands on the lowest free entry
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            found = 1'b0;
            for (int e = 0; e < `RS_DEPTH; e++) begin
                if (disp_valid_i[s] && !found && avail[e]) begin
                    grant_o[s][e] = 1'b1;
                    // Taken, later slots skip it
                    avail[e]      = 1'b0;
                    found         = 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/rs_single_entry.sv
`include "ooo_settings.svh"

module rs_single_entry
    import uop_pkg::*;
    import cdb_pkg::*;
(
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           flush_i,

    // Allocation from dispatch
    input  logic                           disp_enable_i,
    input  rs_entry_t                      entry_i,

    // Leaves the station at this edge
    input  logic                           issue_i,

    // Result broadcast
    input  cdb_packet_t [`CDB_WIDTH-1:0]   cdb_i,

    output rs_entry_t                      entry_o,
    output logic                           empty_o,
    output logic                           ready_o
);

    // ==============================
    // State
    // ==============================

    logic         busy_q;
    rs_entry_t    entry_q;

    // Sources after this cycle's wakeup
    src_operand_t src1_next;
    src_operand_t src2_next;

    // ==============================
    // Occupancy
    // ==============================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            busy_q <= 1'b0;
        end else if (disp_enable_i) begin
            busy_q <= 1'b1;
        end else if (issue_i) begin
            busy_q <= 1'b0;
        end
    end

    // ==============================
    // Payload and operand capture
    // ==============================

    assign src1_next = cdb_snoop(entry_q.src1, cdb_i);
    assign src2_next = cdb_snoop(entry_q.src2, cdb_i);

    always_ff @(posedge clk_i) begin
        if (disp_enable_i) begin
            // Bypass already applied in decode
            entry_q <= entry_i;
        end else if (busy_q) begin
            entry_q.src1 <= src1_next;
            entry_q.src2 <= src2_next;
        end
    end

    // ==============================
    // Status
    // ==============================

    assign entry_o = entry_q;
    assign empty_o = ~busy_q;
    // Registered view, so a wakeup shows one cycle after capture
    assign ready_o = busy_q && entry_q.src1.ready && entry_q.src2.ready;

endmodule

//--- logic/rs.sv
`include "ooo_settings.svh"

module rs
    import uop_pkg::*;
    import cdb_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              flush_i,

    // ==============================
    // Dispatch side
    // ==============================
    input  rs_entry_t   [`DISPATCH_WIDTH-1:0] entry_i,
    input  logic        [`DISPATCH_WIDTH-1:0] entry_valid_i,

    input  cdb_packet_t [`CDB_WIDTH-1:0]      cdb_i,

    // ==============================
    // Issue side
    // ==============================
    input  logic        [`RS_DEPTH-1:0]       issue_enable_i,
    output rs_entry_t   [`RS_DEPTH-1:0]       rs_entries_o,
    output logic        [`RS_DEPTH-1:0]       rs_ready_o,
    output logic                              rs_full_o
);

    logic      [`RS_DEPTH-1:0]                      rs_empty;
    logic      [`RS_DEPTH-1:0]                      disp_enable;
    rs_entry_t [`RS_DEPTH-1:0]                      disp_entry;
    logic      [`DISPATCH_WIDTH-1:0]                disp_valid;
    logic      [`DISPATCH_WIDTH-1:0][`RS_DEPTH-1:0] grant;
    logic      [$clog2(`DISPATCH_WIDTH+1)-1:0]      free_slots;

    // Entry array
    for (genvar i = 0; i < `RS_DEPTH; i++) begin : g_entry
        rs_single_entry u_entry (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .flush_i      (flush_i),
            .disp_enable_i(disp_enable[i]),
            .entry_i      (disp_entry[i]),
            .issue_i      (issue_enable_i[i]),
            .cdb_i        (cdb_i),
            .entry_o      (rs_entries_o[i]),
            .empty_o      (rs_empty[i]),
            .ready_o      (rs_ready_o[i])
        );
    end

    // Nothing is written unless dispatch sees ready
    assign disp_valid = entry_valid_i & {`DISPATCH_WIDTH{~rs_full_o}};

    disp_selector u_disp_sel (
        .empty_i     (rs_empty),
        .disp_valid_i(disp_valid),
        .grant_o     (grant)
    );

    // Route each granted slot to its entry
    always_comb begin
        disp_entry  = '0;
        disp_enable = '0;
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            for (int e = 0; e < `RS_DEPTH; e++) begin
                if (grant[s][e]) begin
                    disp_entry[e]  = entry_i[s];
                    disp_enable[e] = 1'b1;
                end
            end
        end
    end

    // Free count, saturating at the dispatch width
    always_comb begin
        free_slots = '0;
        for (int e = 0; e < `RS_DEPTH; e++) begin
            if (rs_empty[e] && (free_slots < `DISPATCH_WIDTH)) begin
                free_slots = free_slots + 1'b1;
            end
        end
    end

    assign rs_full_o = (free_slots < `DISPATCH_WIDTH);

endmodule

//--- logic/issue_select.sv
`include "ooo_settings.svh"

module issue_select
    import uop_pkg::*;
    import cdb_pkg::*;
(
    input  rs_entry_t [`RS_DEPTH-1:0] rs_entries_i,
    input  logic      [`RS_DEPTH-1:0] rs_ready_i,
    output logic      [`RS_DEPTH-1:0] issue_enable_o,
    output issue_pkt_t                alu_pkt_o,
    output issue_pkt_t                mul_pkt_o
);

    // Entry to lane packet
    function automatic issue_pkt_t make_pkt(input rs_entry_t e);
        issue_pkt_t pkt;
        pkt.valid      = 1'b1;
        pkt.opcode     = e.opcode;
        pkt.dest_tag   = e.dest_tag;
        pkt.src1_value = e.src1.value;
        pkt.src2_value = e.src2.value;
        return pkt;
    endfunction

    // ==============================
    // Oldest-slot-first pick per lane
    // ==============================

    always_comb begin : pick
        logic alu_found;
        logic mul_found;
        alu_found      = 1'b0;
        mul_found      = 1'b0;
        issue_enable_o = '0;
        alu_pkt_o      = '0;
        mul_pkt_o      = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (rs_ready_i[i] && !alu_found && (rs_entries_i[i].fu_type == FU_ALU)) begin
                alu_found         = 1'b1;
                issue_enable_o[i] = 1'b1;
                alu_pkt_o         = make_pkt(rs_entries_i[i]);
            end
            // Independent search, one MUL per cycle
            if (rs_ready_i[i] && !mul_found && (rs_entries_i[i].fu_type == FU_MUL)) begin
                mul_found         = 1'b1;
                issue_enable_o[i] = 1'b1;
                mul_pkt_o         = make_pkt(rs_entries_i[i]);
            end
        end
    end

endmodule

//--- logic/exec_lanes.sv
`include "ooo_settings.svh"

module exec_lanes
    import uop_pkg::*;
    import cdb_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          flush_i,
    input  issue_pkt_t                    alu_pkt_i,
    input  issue_pkt_t                    mul_pkt_i,
    output cdb_packet_t [`CDB_WIDTH-1:0]  cdb_o
);

    // ALU result function
    function automatic logic [`XLEN-1:0] alu_calc(
        input opcode_e          op,
        input logic [`XLEN-1:0] a,
        input logic [`XLEN-1:0] b
    );
        logic [`XLEN-1:0] r;
        case (op)
            ADD:     r = a + b;
            SUB:     r = a - b;
            AND:     r = a & b;
            OR:      r = a | b;
            XOR:     r = a ^ b;
            SLL:     r = a << b[$clog2(`XLEN)-1:0];
            // MUL ops never reach this lane
            default: r = '0;
        endcase
        return r;
    endfunction

    logic                         alu_valid_q;
    logic [`TAG_WIDTH-1:0]        alu_tag_q;
    logic [`XLEN-1:0]             alu_value_q;
    logic                         mul_valid_q [`MUL_STAGES];
    logic [`TAG_WIDTH-1:0]        mul_tag_q   [`MUL_STAGES];
    logic [`XLEN-1:0]             mul_value_q [`MUL_STAGES];
    logic signed [2*`XLEN-1:0]    mul_product;
    logic [`XLEN-1:0]             mul_result;

    // ==============================
    // Valid bits
    // ==============================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            alu_valid_q <= 1'b0;
            for (int s = 0; s < `MUL_STAGES; s++) mul_valid_q[s] <= 1'b0;
        end else begin
            alu_valid_q    <= alu_pkt_i.valid;
            mul_valid_q[0] <= mul_pkt_i.valid;
            for (int s = 1; s < `MUL_STAGES; s++) mul_valid_q[s] <= mul_valid_q[s-1];
        end
    end

    // ==============================
    // Payload
    // ==============================

    // Full signed product, low half serves MUL as well
    assign mul_product = $signed(mul_pkt_i.src1_value) * $signed(mul_pkt_i.src2_value);
    assign mul_result  = (mul_pkt_i.opcode == MULH) ? mul_product[2*`XLEN-1:`XLEN]
                                                    : mul_product[`XLEN-1:0];

    always_ff @(posedge clk_i) begin
        alu_tag_q      <= alu_pkt_i.dest_tag;
        alu_value_q    <= alu_calc(alu_pkt_i.opcode, alu_pkt_i.src1_value, alu_pkt_i.src2_value);
        mul_tag_q[0]   <= mul_pkt_i.dest_tag;
        mul_value_q[0] <= mul_result;
        // Result rides down the remaining stages
        for (int s = 1; s < `MUL_STAGES; s++) begin
            mul_tag_q[s]   <= mul_tag_q[s-1];
            mul_value_q[s] <= mul_value_q[s-1];
        end
    end

    // Port 0 ALU, port 1 MUL
    assign cdb_o[0].valid = alu_valid_q;
    assign cdb_o[0].tag   = alu_tag_q;
    assign cdb_o[0].value = alu_value_q;
    assign cdb_o[1].valid = mul_valid_q[`MUL_STAGES-1];
    assign cdb_o[1].tag   = mul_tag_q[`MUL_STAGES-1];
    assign cdb_o[1].value = mul_value_q[`MUL_STAGES-1];

endmodule

//--- logic/ooo_backend.sv
`include "ooo_settings.svh"

module ooo_backend
    import uop_pkg::*;
    import cdb_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              flush_i,
    input  logic        [`DISPATCH_WIDTH-1:0] disp_valid_i,
    input  disp_uop_t   [`DISPATCH_WIDTH-1:0] disp_uop_i,
    output logic                              disp_ready_o,
    output cdb_packet_t [`CDB_WIDTH-1:0]      cdb_o
);

    rs_entry_t  [`DISPATCH_WIDTH-1:0] entry;
    logic       [`DISPATCH_WIDTH-1:0] entry_valid;
    rs_entry_t  [`RS_DEPTH-1:0]       rs_entries;
    logic       [`RS_DEPTH-1:0]       rs_ready;
    logic       [`RS_DEPTH-1:0]       issue_enable;
    logic                             rs_full;
    issue_pkt_t                       alu_pkt;
    issue_pkt_t                       mul_pkt;

    // Decode with bypass from the live CDB
    uop_decode u_decode (
        .disp_valid_i (disp_valid_i),
        .disp_uop_i   (disp_uop_i),
        .cdb_i        (cdb_o),
        .entry_o      (entry),
        .entry_valid_o(entry_valid)
    );

    rs u_rs (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .entry_i       (entry),
        .entry_valid_i (entry_valid),
        .cdb_i         (cdb_o),
        .issue_enable_i(issue_enable),
        .rs_entries_o  (rs_entries),
        .rs_ready_o    (rs_ready),
        .rs_full_o     (rs_full)
    );

    issue_select u_issue (
        .rs_entries_i  (rs_entries),
        .rs_ready_i    (rs_ready),
        .issue_enable_o(issue_enable),
        .alu_pkt_o     (alu_pkt),
        .mul_pkt_o     (mul_pkt)
    );

    exec_lanes u_exec (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .alu_pkt_i(alu_pkt),
        .mul_pkt_i(mul_pkt),
        .cdb_o    (cdb_o)
    );

    // Room for a full dispatch group
    assign disp_ready_o = ~rs_full;

endmodule

//--- verif/ooo_backend_tb.sv
`include "ooo_settings.svh"

module ooo_backend_tb
    import uop_pkg::*;
    import cdb_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // ==============================
    // Run sizing
    // ==============================

    // 40 + 40 + 9 + 40 + 12 + 20 micro-ops over all tests
    localparam int TOTAL_OPS   = 161;
    localparam int CYCLE_LIMIT = TOTAL_OPS * (`MUL_STAGES + `RS_DEPTH) + 200;

    // Longest wait for stragglers after the last dispatch of a test
    localparam int DRAIN_LIMIT = (`RS_DEPTH + `MUL_STAGES + 1) * (`MUL_STAGES + `RS_DEPTH);

    // Tag life cycle in the model
    localparam int ST_FREE   = 0;
    localparam int ST_PEND   = 1;
    localparam int ST_FLIGHT = 2;
    localparam int ST_DONE   = 3;
    localparam int ST_SQUASH = 4;

    typedef enum {M_INDEP, M_CHAIN, M_FLOOD, M_MULMIX} mode_e;

    logic                                clk;
    logic                                rst_n;
    logic                                flush;
    logic        [`DISPATCH_WIDTH-1:0]   disp_valid;
    disp_uop_t   [`DISPATCH_WIDTH-1:0]   disp_uop;
    logic                                disp_ready;
    cdb_packet_t [`CDB_WIDTH-1:0]        cdb;

    int                                  tag_state [`PHYS_REGS];
    logic        [`XLEN-1:0]             exp_val   [`PHYS_REGS];
    disp_uop_t   [`DISPATCH_WIDTH-1:0]   pend_uop;
    logic        [`DISPATCH_WIDTH-1:0]   pend_valid;
    mode_e                               mode;
    string                               test_name;
    int                                  ops_left;
    int                                  ops_sent;
    int                                  in_flight;
    int                                  flood_tag;
    int                                  test_accepts;
    int                                  test_bcasts;
    int                                  test_errors;
    int                                  total_errors = 0;
    int                                  tests_run = 0;
    int                                  tests_failed = 0;
    int                                  cycle_count = 0;
    bit                                  stall_seen;

    ooo_backend uut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .flush_i     (flush),
        .disp_valid_i(disp_valid),
        .disp_uop_i  (disp_uop),
        .disp_ready_o(disp_ready),
        .cdb_o       (cdb)
    );

    always #2 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles in %s, results never arrived", cycle_count,
                     test_name);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ==============================
    // Reference model
    // ==============================

    function automatic logic [`XLEN-1:0] model_result(
        input opcode_e          op,
        input logic [`XLEN-1:0] a,
        input logic [`XLEN-1:0] b
    );
        longint prod;
        // Signed 64-bit product covers both multiply flavours
        prod = longint'($signed(a)) * longint'($signed(b));
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << (b % `XLEN);
            MUL:     return prod[`XLEN-1:0];
            default: return prod[2*`XLEN-1:`XLEN];
        endcase
    endfunction

    function automatic bit is_live(input int tag);
        return tag_state[tag] inside {ST_PEND, ST_FLIGHT, ST_DONE};
    endfunction

    // Scans from a random start and gives -1 when nothing fits
    function automatic int pick_tag(input bit want_live);
        int start;
        int t;
        start = $urandom_range(0, `PHYS_REGS - 1);
        for (int i = 0; i < `PHYS_REGS; i++) begin
            t = (start + i) % `PHYS_REGS;
            if (want_live ? is_live(t) : (tag_state[t] == ST_FREE)) return t;
        end
        return -1;
    endfunction

    function automatic src_operand_t ready_src(input logic [`XLEN-1:0] value);
        src_operand_t src;
        src.tag   = '0;
        src.ready = 1'b1;
        src.value = value;
        return src;
    endfunction

    // Waits on a live producer, else takes its known result
    function automatic src_operand_t wait_src(input int tag);
        src_operand_t src;
        src.tag = tag[`TAG_WIDTH-1:0];
        if (is_live(tag)) begin
            src.ready = 1'b0;
            // Junk value that the broadcast must replace
            src.value = $urandom();
        end else begin
            src.ready = 1'b1;
            src.value = exp_val[tag];
        end
        return src;
    endfunction

    // Stalled source whose producer already went by
    function automatic src_operand_t refresh_src(input src_operand_t src);
        src_operand_t res;
        res = src;
        if (!src.ready && tag_state[src.tag] == ST_FREE) begin
            res.ready = 1'b1;
            res.value = exp_val[src.tag];
        end
        return res;
    endfunction

    // ==============================
    // Reporting
    // ==============================

    task automatic report_mismatch(input int tag, input logic [`XLEN-1:0] expv,
                                   input logic [`XLEN-1:0] actv);
        $display("Fail %s: tag %0d expected %h actual %h", test_name, tag, expv, actv);
        test_errors++;
        total_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error in %s: %s", test_name, msg);
        test_errors++;
        total_errors++;
    endtask

    // ==============================
    // Stimulus and monitor
    // ==============================

    // Matches by tag, since completion order is free
    task automatic check_cdb();
        int t;
        for (int p = 0; p < `CDB_WIDTH; p++) begin
            if (cdb[p].valid) begin
                t = cdb[p].tag;
                if (tag_state[t] == ST_SQUASH) begin
                    report_problem($sformatf("squashed tag %0d broadcast on port %0d", t, p));
                end else if (tag_state[t] != ST_FLIGHT) begin
                    report_problem($sformatf("tag %0d broadcast with no op waiting on it", t));
                end else begin
                    if (cdb[p].value !== exp_val[t]) report_mismatch(t, exp_val[t], cdb[p].value);
                    tag_state[t] = ST_DONE;
                    test_bcasts++;
                    in_flight--;
                end
            end
        end
    endtask

    task automatic new_uop(input int s);
        disp_uop_t        u;
        int               dest;
        int               live;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        dest = pick_tag(1'b0);
        if (dest < 0) return;
        u.opcode = opcode_e'($urandom_range(0, 7));
        if (mode == M_MULMIX && $urandom_range(0, 3) != 0) begin
            u.opcode = $urandom_range(0, 1) ? MULH : MUL;
        end
        u.dest_tag = dest[`TAG_WIDTH-1:0];
        u.src1     = ready_src($urandom());
        u.src2     = ready_src($urandom());
        if (mode == M_CHAIN) begin
            live = pick_tag(1'b1);
            if (live >= 0 && $urandom_range(0, 9) < 7) u.src1 = wait_src(live);
            live = pick_tag(1'b1);
            if (live >= 0 && $urandom_range(0, 9) < 4) u.src2 = wait_src(live);
        end else if (mode == M_FLOOD) begin
            // Head of the flood that all later ops hang on
            if (ops_sent == 0) begin
                u.opcode  = MUL;
                flood_tag = dest;
            end else begin
                u.src1 = wait_src(flood_tag);
            end
        end
        a = u.src1.ready ? u.src1.value : exp_val[u.src1.tag];
        b = u.src2.ready ? u.src2.value : exp_val[u.src2.tag];
        exp_val[dest]   = model_result(u.opcode, a, b);
        tag_state[dest] = ST_PEND;
        pend_uop[s]     = u;
        pend_valid[s]   = 1'b1;
        ops_left--;
        ops_sent++;
    endtask

    // One cycle with all work at the falling edge
    task automatic clock_step(input bit gen_en);
        @(negedge clk);
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            if (pend_valid[s]) begin
                pend_uop[s].src1 = refresh_src(pend_uop[s].src1);
                pend_uop[s].src2 = refresh_src(pend_uop[s].src2);
            end
        end
        check_cdb();
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            if (gen_en && !pend_valid[s] && ops_left > 0) new_uop(s);
        end
        disp_valid = pend_valid;
        disp_uop   = pend_uop;
        // Ready is station state only, so it holds until the next rising edge
        if (disp_ready) begin
            for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
                if (pend_valid[s]) begin
                    tag_state[pend_uop[s].dest_tag] = ST_FLIGHT;
                    test_accepts++;
                    in_flight++;
                end
            end
            pend_valid = '0;
        end else if (|pend_valid) begin
            stall_seen = 1'b1;
        end
        for (int t = 0; t < `PHYS_REGS; t++) begin
            if (tag_state[t] == ST_DONE) tag_state[t] = ST_FREE;
        end
    endtask

    task automatic flush_all();
        @(negedge clk);
        check_cdb();
        flush      = 1'b1;
        disp_valid = '0;
        pend_valid = '0;
        // Squashed ops leave the accept count
        test_accepts -= in_flight;
        in_flight     = 0;
        for (int t = 0; t < `PHYS_REGS; t++) begin
            if (tag_state[t] inside {ST_PEND, ST_FLIGHT}) tag_state[t] = ST_SQUASH;
            else if (tag_state[t] == ST_DONE) tag_state[t] = ST_FREE;
        end
        @(negedge clk);
        flush = 1'b0;
        if (!disp_ready) report_problem("disp_ready_o low right after flush");
        check_cdb();
    endtask

    // ==============================
    // Test sequencing
    // ==============================

    task automatic begin_test(input string name, input mode_e m, input int n_ops);
        test_name    = name;
        mode         = m;
        ops_left     = n_ops;
        ops_sent     = 0;
        test_accepts = 0;
        test_bcasts  = 0;
        test_errors  = 0;
        stall_seen   = 1'b0;
    endtask

    task automatic end_test();
        if (test_bcasts != test_accepts) begin
            report_problem($sformatf("%0d accepted but %0d broadcast", test_accepts,
                                     test_bcasts));
        end
        $display("Test %-9s accepted %3d  broadcast %3d  errors %0d", test_name, test_accepts,
                 test_bcasts, test_errors);
        tests_run++;
        if (test_errors != 0) tests_failed++;
    endtask

    task automatic send_and_drain();
        int wait_cycles;
        wait_cycles = 0;
        while (ops_left > 0 || |pend_valid) clock_step(1'b1);
        // A lost op runs out the wait and leaves the counts unequal
        while (in_flight > 0 && wait_cycles < DRAIN_LIMIT) begin
            clock_step(1'b0);
            wait_cycles++;
        end
    endtask

    task automatic run_test(input string name, input mode_e m, input int n_ops);
        begin_test(name, m, n_ops);
        send_and_drain();
        if (m == M_FLOOD && !stall_seen) report_problem("disp_ready_o never dropped");
        end_test();
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        flush      = 1'b0;
        disp_valid = '0;
        disp_uop   = '0;
        pend_uop   = '0;
        pend_valid = '0;
        in_flight  = 0;
        test_name  = "reset";
        void'($urandom(32'h9cfb7189));
        for (int t = 0; t < `PHYS_REGS; t++) tag_state[t] = ST_FREE;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Quiet bus and open dispatch after reset
        begin_test("reset", M_INDEP, 0);
        repeat (3) begin
            @(negedge clk);
            for (int p = 0; p < `CDB_WIDTH; p++) begin
                if (cdb[p].valid) report_problem($sformatf("CDB port %0d valid after reset", p));
            end
            if (!disp_ready) report_problem("disp_ready_o low after reset");
        end
        end_test();

        run_test("indep", M_INDEP, 40);
        run_test("chain", M_CHAIN, 40);
        run_test("flood", M_FLOOD, 9);
        run_test("mulmix", M_MULMIX, 40);

        // Flush mid-stream and follow with a fresh batch
        begin_test("flush", M_CHAIN, 12);
        while (ops_left > 0 || |pend_valid) clock_step(1'b1);
        flush_all();
        ops_left = 20;
        send_and_drain();
        end_test();

        $display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+logic
logic/uop_pkg.sv
logic/cdb_pkg.sv
logic/uop_decode.sv
logic/disp_selector.sv
logic/rs_single_entry.sv
logic/rs.sv
logic/issue_select.sv
logic/exec_lanes.sv
logic/ooo_backend.sv
verif/ooo_backend_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = ooo_backend_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qxF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
